//--- hw/pp_pkg.sv
package pp_pkg;

	localparam int DATA_NBITS      = 128;
	localparam int CHUNK_LEN_NBITS = 12;
	localparam int CREDIT_NBITS    = 13; // one bit above the chunk length so a full buffer fits.
	localparam int RCI_NBITS       = 8;

	// field positions in the header beat, counted from the msb of the data word.
	localparam int TYPE_MSB = 127;
	localparam int LEN_MSB  = 123;
	localparam int TIME_MSB = 111;

	typedef enum logic [3:0] {
		CHUNK_PATH = 4'h0,
		CHUNK_INST = 4'h1,
		CHUNK_PD   = 4'h2,
		CHUNK_CTRL = 4'h3
	} chunk_type_e;

	typedef enum logic {
		SRC_LH  = 1'b0,
		SRC_SIG = 1'b1
	} src_e;

	typedef struct packed {
		logic                  sop;
		logic                  eop;
		logic [DATA_NBITS-1:0] data;
	} beat_t;

	typedef struct packed {
		logic                 discard;
		logic [RCI_NBITS-1:0] rci;
	} src_meta_t;

	typedef struct packed {
		chunk_type_e                chunk_type;
		logic [CHUNK_LEN_NBITS-1:0] chunk_len;
		logic [31:0]                creation_time;
	} hdr_t;

	typedef struct packed {
		beat_t     beat;
		src_meta_t meta;
		hdr_t      hdr;
		src_e      src;
	} dec_beat_t;

	typedef struct packed {
		src_e                       src;
		logic [RCI_NBITS-1:0]       rci;
		logic [CHUNK_LEN_NBITS-1:0] chunk_len;
		logic [31:0]                creation_time;
	} out_meta_t;

endpackage

//--- hw/pp_lh_fifo.sv
`timescale 1ns/100ps

module pp_lh_fifo
	import pp_pkg::*;
#(
	parameter int LH_FIFO_DEPTH = 16
) (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      wr,
	input  beat_t     wr_beat,
	input  src_meta_t wr_meta,
	input  logic      rd,
	output logic      ready,
	output logic      empty,
	output beat_t     head_beat,
	output src_meta_t head_meta
);

	localparam int PTR_NBITS = $clog2(LH_FIFO_DEPTH);
	localparam int CNT_NBITS = $clog2(LH_FIFO_DEPTH + 1);

	beat_t                mem_beat [LH_FIFO_DEPTH];
	src_meta_t            mem_meta [LH_FIFO_DEPTH];
	src_meta_t            pkt_meta;
	src_meta_t            entry_meta;
	logic [PTR_NBITS-1:0] wr_ptr;
	logic [PTR_NBITS-1:0] rd_ptr;
	logic [CNT_NBITS-1:0] count;
	logic                 push;
	logic                 pop;

	assign ready = count != CNT_NBITS'(LH_FIFO_DEPTH);
	assign empty = count == '0;
	assign push = wr && ready;
	assign pop = rd && !empty;
	assign entry_meta = wr_beat.sop ? wr_meta : pkt_meta; // later beats reuse the sop meta.
	assign head_beat = mem_beat[rd_ptr];
	assign head_meta = mem_meta[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem_beat[wr_ptr] <= wr_beat;
			mem_meta[wr_ptr] <= entry_meta;
			if (wr_beat.sop) begin
				pkt_meta <= wr_meta;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_NBITS'(LH_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_NBITS'(LH_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- hw/pp_source_arbiter.sv
`timescale 1ns/100ps

module pp_source_arbiter
	import pp_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      fifo_empty,
	input  beat_t     fifo_beat,
	input  src_meta_t fifo_meta,
	output logic      fifo_rd,
	input  logic      sig_valid,
	input  beat_t     sig_beat,
	input  src_meta_t sig_meta,
	output logic      sig_ready,
	output logic      sel_valid,
	output beat_t     sel_beat,
	output src_meta_t sel_meta,
	output src_e      sel_src
);

	src_e sel_q;
	src_e sel_d;
	logic in_pkt; // a packet of the selected source is open.
	logic lh_take;
	logic sig_take;
	logic accept;
	logic at_boundary;

	assign sig_ready = sel_q == SRC_SIG;
	assign lh_take = (sel_q == SRC_LH) && !fifo_empty;
	assign sig_take = sig_ready && sig_valid;
	assign accept = lh_take || sig_take;
	assign fifo_rd = lh_take;

	assign sel_valid = accept;
	assign sel_beat = sig_ready ? sig_beat : fifo_beat;
	assign sel_meta = sig_ready ? sig_meta : fifo_meta;
	assign sel_src = sel_q;

	// idle between packets, or closing one with this beat.
	assign at_boundary = accept ? sel_beat.eop : !in_pkt;

	always_comb begin
		sel_d = sel_q;
		case (sel_q)
			SRC_LH: begin
				if (at_boundary && sig_valid) begin
					sel_d = SRC_SIG;
				end
			end
			SRC_SIG: begin
				if (at_boundary && !fifo_empty) begin
					sel_d = SRC_LH;
				end
			end
			default: sel_d = SRC_LH;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sel_q <= SRC_LH;
			in_pkt <= 1'b0;
		end else begin
			sel_q <= sel_d;
			if (accept) begin
				in_pkt <= !sel_beat.eop;
			end
		end
	end

endmodule

//--- hw/pp_chunk_decode.sv
`timescale 1ns/100ps

module pp_chunk_decode
	import pp_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      sel_valid,
	input  beat_t     sel_beat,
	input  src_meta_t sel_meta,
	input  src_e      sel_src,
	output logic      dec_valid,
	output dec_beat_t dec
);

	hdr_t sop_hdr;

	// the header sits in the top bits of the first beat of every chunk.
	always_comb begin
		sop_hdr.chunk_type = chunk_type_e'(sel_beat.data[TYPE_MSB -: 4]);
		sop_hdr.chunk_len = sel_beat.data[LEN_MSB -: CHUNK_LEN_NBITS];
		sop_hdr.creation_time = sel_beat.data[TIME_MSB -: 32];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= sel_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (sel_valid) begin
			dec.beat <= sel_beat;
			dec.src <= sel_src;
			if (sel_beat.sop) begin
				dec.meta <= sel_meta; // held until the next sop.
				dec.hdr <= sop_hdr;
			end
		end
	end

endmodule

//--- hw/pp_credit_check.sv
`timescale 1ns/100ps

module pp_credit_check
	import pp_pkg::*;
#(
	parameter int BUF_BYTES = 1024
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       dec_valid,
	input  dec_beat_t                  dec,
	input  logic                       rel_valid,
	input  logic [CHUNK_LEN_NBITS-1:0] rel_len,
	output logic                       fwd_valid,
	output dec_beat_t                  fwd
);

	logic [CREDIT_NBITS-1:0] credit;
	logic [CREDIT_NBITS-1:0] chunk_cost;
	logic [CREDIT_NBITS-1:0] credit_back;
	logic [CREDIT_NBITS-1:0] credit_used;
	logic                    keep_pkt; // verdict of the chunk now in flight.
	logic                    keep_sop;
	logic                    keep_beat;
	logic                    charge;

	assign chunk_cost = CREDIT_NBITS'(dec.hdr.chunk_len);
	assign keep_sop = (dec.hdr.chunk_type == CHUNK_PATH) && !dec.meta.discard &&
		(chunk_cost <= credit);
	assign keep_beat = dec.beat.sop ? keep_sop : keep_pkt;

	// dropped chunks take no credit.
	assign charge = dec_valid && dec.beat.sop && keep_sop;
	assign credit_used = charge ? chunk_cost : '0;
	assign credit_back = rel_valid ? CREDIT_NBITS'(rel_len) : '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credit <= CREDIT_NBITS'(BUF_BYTES);
			keep_pkt <= 1'b0;
			fwd_valid <= 1'b0;
		end else begin
			credit <= credit - credit_used + credit_back;
			if (dec_valid && dec.beat.sop) begin
				keep_pkt <= keep_sop;
			end
			fwd_valid <= dec_valid && keep_beat;
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid) begin
			fwd <= dec;
		end
	end

endmodule

//--- hw/pp_chunk_output.sv
`timescale 1ns/100ps

module pp_chunk_output
	import pp_pkg::*;
(
	input  logic      fwd_valid,
	input  dec_beat_t fwd,
	output logic      out_valid,
	output beat_t     out_beat,
	output out_meta_t out_meta
);

	assign out_valid = fwd_valid;
	assign out_beat = fwd.beat;

	// every beat carries the meta of its chunk.
	always_comb begin
		out_meta.src = fwd.src;
		out_meta.rci = fwd.meta.rci;
		out_meta.chunk_len = fwd.hdr.chunk_len;
		out_meta.creation_time = fwd.hdr.creation_time;
	end

endmodule

//--- hw/pp_front_end.sv
`timescale 1ns/100ps

module pp_front_end
	import pp_pkg::*;
#(
	parameter int LH_FIFO_DEPTH = 16,
	parameter int BUF_BYTES     = 1024
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       lh_valid,
	input  beat_t                      lh_beat,
	input  src_meta_t                  lh_meta,
	output logic                       lh_ready,
	input  logic                       sig_valid,
	input  beat_t                      sig_beat,
	input  src_meta_t                  sig_meta,
	output logic                       sig_ready,
	input  logic                       rel_valid,
	input  logic [CHUNK_LEN_NBITS-1:0] rel_len,
	output logic                       out_valid,
	output beat_t                      out_beat,
	output out_meta_t                  out_meta
);

	logic      fifo_empty;
	logic      fifo_rd;
	beat_t     fifo_beat;
	src_meta_t fifo_meta;
	logic      sel_valid;
	beat_t     sel_beat;
	src_meta_t sel_meta;
	src_e      sel_src;
	logic      dec_valid;
	dec_beat_t dec;
	logic      fwd_valid;
	dec_beat_t fwd;

	pp_lh_fifo #(
		.LH_FIFO_DEPTH(LH_FIFO_DEPTH)
	) u_lh_fifo (
		.clk       (clk),
		.arst_n    (arst_n),
		.wr        (lh_valid),
		.wr_beat   (lh_beat),
		.wr_meta   (lh_meta),
		.rd        (fifo_rd),
		.ready     (lh_ready),
		.empty     (fifo_empty),
		.head_beat (fifo_beat),
		.head_meta (fifo_meta)
	);

	pp_source_arbiter u_source_arbiter (
		.clk        (clk),
		.arst_n     (arst_n),
		.fifo_empty (fifo_empty),
		.fifo_beat  (fifo_beat),
		.fifo_meta  (fifo_meta),
		.fifo_rd    (fifo_rd),
		.sig_valid  (sig_valid),
		.sig_beat   (sig_beat),
		.sig_meta   (sig_meta),
		.sig_ready  (sig_ready),
		.sel_valid  (sel_valid),
		.sel_beat   (sel_beat),
		.sel_meta   (sel_meta),
		.sel_src    (sel_src)
	);

	pp_chunk_decode u_chunk_decode (
		.clk       (clk),
		.arst_n    (arst_n),
		.sel_valid (sel_valid),
		.sel_beat  (sel_beat),
		.sel_meta  (sel_meta),
		.sel_src   (sel_src),
		.dec_valid (dec_valid),
		.dec       (dec)
	);

	pp_credit_check #(
		.BUF_BYTES(BUF_BYTES)
	) u_credit_check (
		.clk       (clk),
		.arst_n    (arst_n),
		.dec_valid (dec_valid),
		.dec       (dec),
		.rel_valid (rel_valid),
		.rel_len   (rel_len),
		.fwd_valid (fwd_valid),
		.fwd       (fwd)
	);

	pp_chunk_output u_chunk_output (
		.fwd_valid (fwd_valid),
		.fwd       (fwd),
		.out_valid (out_valid),
		.out_beat  (out_beat),
		.out_meta  (out_meta)
	);

endmodule

//--- include/pp_tb_checks.svh
`ifndef PP_TB_CHECKS_SVH
`define PP_TB_CHECKS_SVH

int mismatch_count = 0;
int failure_count = 0;

task automatic report_failure(input string what);
	failure_count++;
	$display("failure at time %0t: %s", $time, what);
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		mismatch_count++;
		$display("mismatch %s at time %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
	end
endtask

task automatic check_beat(input string name, input beat_t got, input beat_t exp);
	if (got !== exp) begin
		mismatch_count++;
		$display("mismatch %s at time %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
	end
endtask

task automatic check_meta(input string name, input out_meta_t got, input out_meta_t exp);
	if (got !== exp) begin
		mismatch_count++;
		$display("mismatch %s at time %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
	end
endtask

task automatic check_latency(input string name, input time got, input time exp);
	if (got !== exp) begin
		mismatch_count++;
		$display("mismatch %s: arrived at 0x%h, expected at 0x%h", name, got, exp);
	end
endtask

task automatic print_counts();
	$display("%0d mismatches, %0d other failures", mismatch_count, failure_count);
endtask

`endif

//--- tests/tb_pp_front_end.sv
`timescale 1ns/100ps

module tb_pp_front_end
	import pp_pkg::*;
;

	localparam int CLK_PERIOD = 8;
	localparam int LH_FIFO_DEPTH = 16;
	localparam int BUF_BYTES = 1024;
	localparam int TEST_BEATS = 4 + 5 + 24 + 10 + 10; // beats sent by the five tests.
	localparam int WATCHDOG_CYCLES = TEST_BEATS * 20;
	localparam int DRAIN_CYCLES = 4 * LH_FIFO_DEPTH; // a full fifo plus the pipe drains well within this.

	typedef struct packed {
		beat_t     beat;
		out_meta_t meta;
	} exp_beat_t;

	logic                       clk = 1'b0;
	logic                       arst_n;
	logic                       lh_valid;
	beat_t                      lh_beat;
	src_meta_t                  lh_meta;
	logic                       lh_ready;
	logic                       sig_valid;
	beat_t                      sig_beat;
	src_meta_t                  sig_meta;
	logic                       sig_ready;
	logic                       rel_valid;
	logic [CHUNK_LEN_NBITS-1:0] rel_len;
	logic                       out_valid;
	beat_t                      out_beat;
	out_meta_t                  out_meta;

	exp_beat_t lh_q[$];
	exp_beat_t sig_q[$];
	time       sig_due_q[$]; // sample time of each expected signature beat.
	exp_beat_t mon_exp;
	int        model_credit = BUF_BYTES;
	logic      pkt_open = 1'b0;
	src_e      pkt_src = SRC_LH;

	`include "pp_tb_checks.svh"

	pp_front_end #(
		.LH_FIFO_DEPTH(LH_FIFO_DEPTH),
		.BUF_BYTES    (BUF_BYTES)
	) dut (.*);

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired, %0d local host and %0d signature beats never arrived",
			lh_q.size(), sig_q.size());
		$display("SIMULATION FAILED");
		$finish;
	end

	always @(negedge clk) begin
		if (arst_n && out_valid) begin
			if ((out_beat.sop == pkt_open) || (pkt_open && out_meta.src != pkt_src)) begin
				report_failure("output beats of two packets interleave");
			end
			if (out_meta.src == SRC_SIG && sig_q.size() > 0) begin
				check_latency("signature beat latency", $time, sig_due_q.pop_front());
				mon_exp = sig_q.pop_front();
			end else if (out_meta.src == SRC_LH && lh_q.size() > 0) begin
				mon_exp = lh_q.pop_front();
			end else begin
				report_failure("an output beat arrived that was never expected");
				mon_exp = {out_beat, out_meta};
			end
			check_beat("out_beat", out_beat, mon_exp.beat);
			check_meta("out_meta", out_meta, mon_exp.meta);
			pkt_open = !out_beat.eop;
			pkt_src = out_meta.src;
		end
	end

	function automatic beat_t make_beat(input logic sop, input logic eop, input hdr_t hdr);
		beat_t b;
		b.sop = sop;
		b.eop = eop;
		b.data = {$urandom, $urandom, $urandom, $urandom};
		if (sop) begin
			b.data[127:124] = hdr.chunk_type;
			b.data[123:112] = hdr.chunk_len;
			b.data[111:80] = hdr.creation_time;
		end
		return b;
	endfunction

	task automatic drive_beat(input src_e src, input beat_t b, input src_meta_t m,
		input logic keep, input exp_beat_t e);
		@(negedge clk);
		if (src == SRC_LH) begin
			lh_valid = 1'b1;
			lh_beat = b;
			lh_meta = m;
			while (!lh_ready) @(negedge clk);
			if (keep) begin
				lh_q.push_back(e);
			end
		end else begin
			sig_valid = 1'b1;
			sig_beat = b;
			sig_meta = m;
			while (!sig_ready) @(negedge clk);
			if (keep) begin
				sig_q.push_back(e);
				sig_due_q.push_back($time + 2 * CLK_PERIOD); // transfers on the next edge.
			end
		end
	endtask

	task automatic idle_source(input src_e src, input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			if (src == SRC_LH) begin
				lh_valid = 1'b0;
			end else begin
				sig_valid = 1'b0;
			end
		end
	endtask

	task automatic send_chunk(input src_e src, input chunk_type_e ctype, input logic discard,
		input int len, input int nbeats, input int max_gap);
		hdr_t      hdr;
		src_meta_t m;
		src_meta_t beat_meta;
		exp_beat_t e;
		logic      keep;
		hdr.chunk_type = ctype;
		hdr.chunk_len = CHUNK_LEN_NBITS'(len);
		hdr.creation_time = $urandom;
		m = $urandom;
		m.discard = discard;
		keep = (ctype == CHUNK_PATH) && !discard && (len <= model_credit);
		if (keep) begin
			model_credit -= len;
		end
		e.meta = '{src: src, rci: m.rci, chunk_len: hdr.chunk_len,
			creation_time: hdr.creation_time};
		for (int i = 0; i < nbeats; i++) begin
			e.beat = make_beat(i == 0, i == nbeats - 1, hdr);
			beat_meta = $urandom; // only the sop meta belongs to the chunk.
			if (i == 0) begin
				beat_meta = m;
			end
			drive_beat(src, e.beat, beat_meta, keep, e);
			idle_source(src, $urandom_range(max_gap, 0));
		end
		idle_source(src, 1);
	endtask

	task automatic release_credit(input int len);
		@(negedge clk);
		rel_valid = 1'b1;
		rel_len = CHUNK_LEN_NBITS'(len);
		model_credit += len;
		@(negedge clk);
		rel_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while ((lh_q.size() > 0 || sig_q.size() > 0) && waited < DRAIN_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		repeat (2) @(negedge clk); // headers still in the pipe get their verdict.
	endtask

	task automatic settle_credit();
		wait_drain();
		if (model_credit < BUF_BYTES) begin
			release_credit(BUF_BYTES - model_credit);
		end
	endtask

	task automatic test_lh_chunk();
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("sig_ready", sig_ready, 1'b0);
		check_flag("lh_ready", lh_ready, 1'b1);
		send_chunk(SRC_LH, CHUNK_PATH, 1'b0, 200, 4, 0);
		settle_credit();
	endtask

	task automatic test_sig_gaps();
		send_chunk(SRC_SIG, CHUNK_PATH, 1'b0, 333, 5, 3);
		settle_credit();
	endtask

	task automatic test_both_sources();
		fork
			repeat (4) send_chunk(SRC_LH, CHUNK_PATH, 1'b0, 40, 3, 2);
			repeat (4) send_chunk(SRC_SIG, CHUNK_PATH, 1'b0, 60, 3, 2);
		join
		settle_credit();
	endtask

	task automatic test_drops();
		send_chunk(SRC_LH, CHUNK_INST, 1'b0, 64, 2, 0);
		send_chunk(SRC_LH, CHUNK_PD, 1'b0, 64, 2, 0);
		send_chunk(SRC_SIG, CHUNK_CTRL, 1'b0, 64, 2, 1);
		send_chunk(SRC_SIG, CHUNK_PATH, 1'b1, 64, 2, 1);
		send_chunk(SRC_LH, CHUNK_PATH, 1'b0, BUF_BYTES, 2, 0);
		settle_credit();
	endtask

	task automatic test_credit_limit();
		repeat (4) send_chunk(SRC_SIG, CHUNK_PATH, 1'b0, 300, 2, 0); // the fourth one is dropped.
		wait_drain();
		release_credit(300);
		send_chunk(SRC_SIG, CHUNK_PATH, 1'b0, 300, 2, 0);
		settle_credit();
	endtask

	initial begin
		void'($urandom(32'ha387_c62d));
		arst_n = 1'b0;
		lh_valid = 1'b0;
		lh_beat = '0;
		lh_meta = '0;
		sig_valid = 1'b0;
		sig_beat = '0;
		sig_meta = '0;
		rel_valid = 1'b0;
		rel_len = '0;
		repeat (3) @(negedge clk);
		arst_n = 1'b1;
		test_lh_chunk();
		test_sig_gaps();
		test_both_sources();
		test_drops();
		test_credit_limit();
		if (lh_q.size() + sig_q.size() > 0) begin
			report_failure("expected beats never arrived at the output");
		end
		print_counts();
		if (mismatch_count + failure_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+include
hw/pp_pkg.sv
hw/pp_lh_fifo.sv
hw/pp_source_arbiter.sv
hw/pp_chunk_decode.sv
hw/pp_credit_check.sv
hw/pp_chunk_output.sv
hw/pp_front_end.sv
tests/tb_pp_front_end.sv

//--- Bender.yml
package:
  name: pp_front_end

sources:
  - files:
      - hw/pp_pkg.sv
      - hw/pp_lh_fifo.sv
      - hw/pp_source_arbiter.sv
      - hw/pp_chunk_decode.sv
      - hw/pp_credit_check.sv
      - hw/pp_chunk_output.sv
      - hw/pp_front_end.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_pp_front_end.sv
